/* Makefile */
# Verilator build and run for the CIC decimator testbench

VERILATOR ?= verilator
TOP ?= cic_tb
FILELIST ?= sources.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= *** TEST PASSED ***
VFLAGS ?= --binary --timing --assert -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST))
BINARY := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: run

# rebuilt only when a source or the file list changes
$(BINARY): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BINARY)
	./$(BINARY) | tee $(LOG)
	grep -qF '$(PASS_TEXT)' $(LOG)

check:
	@grep -qF '$(PASS_TEXT)' $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/cic_golden.txt */
// columns: rate_log2, input value, sample count, expected settled output (all hex)
// values are 16-bit two's complement; every line changes the rate from the line before
0 1234 0008 1234
1 edcc 000b edcc
0 7fff 0006 7fff
2 8000 0013 8000
0 8000 0005 8000
3 7fff 0023 7fff
0 ffff 0004 ffff
4 0001 0046 0001
5 ff00 0082 ff00
6 4000 0104 4000
7 c000 0203 c000
8 2aaa 0406 2aaa
7 d555 0208 d555
1 7fff 0009 7fff
8 8000 0400 8000
2 0000 0010 0000
5 1357 0096 1357
0 0001 0007 0001
4 fffe 0043 fffe
3 8001 0028 8001
6 7ffe 0100 7ffe
0 5a5a 000a 5a5a
2 a5a5 0014 a5a5
1 0003 0008 0003

/* dv/cic_tb.sv */
// golden file is read from the project root; consecutive golden lines must change the rate
`timescale 1ns/100ps
`default_nettype none

module cic_tb
	import cic_pkg::*;
();

	localparam logic [31:0] SEED = 32'hd471_a7ff;
	localparam int TIMEOUT_MARGIN = 20;
	localparam int CYCLES_PER_SAMPLE = 4;
	localparam int SETTLE_CYCLES = 3;
	localparam int DRAIN_CYCLES = 12;
	localparam int MAX_TESTS = 64;
	localparam GOLDEN_FILE = "dv/cic_golden.txt";

	logic        clock;
	logic        arst_n;
	rate_log2_t  rate_log2;
	logic        in_strobe;
	in_sample_t  in_data;
	logic        out_strobe;
	out_sample_t out_data;

	// four words per test give rate_log2, value, count and expected
	logic [15:0] golden [MAX_TESTS*4];
	int          num_tests = 0;
	int          cycle_limit = 0;
	int          cycles = 0;
	int          out_total = 0;
	int          errors = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;
	logic [31:0] rand_state;
	rate_log2_t  cur_rate;
	out_sample_t cur_expected;

	clock_gen i_clock_gen (
		.clock  (clock),
		.arst_n (arst_n)
	);

	cic_decimator i_cic_decimator (
		.clock      (clock),
		.arst_n     (arst_n),
		.rate_log2  (rate_log2),
		.in_strobe  (in_strobe),
		.in_data    (in_data),
		.out_strobe (out_strobe),
		.out_data   (out_data)
	);

	function automatic logic [31:0] next_random(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic report_mismatch(input string name, input int expected, input int actual);
		$display("FAILED at %0t ns: %s expected %0d got %0d", $time, name, expected, actual);
		errors++;
	endtask

	task automatic record_result(input string label, input int err_before);
		if (errors == err_before)
		begin
			tests_passed++;
			$display("%s: pass", label);
		end
		else
		begin
			tests_failed++;
			$display("%s: fail", label);
		end
	endtask

	// unused entries get a fill with an all-ones top byte, which ends the test list
	task automatic load_golden();
		int i;
		int total;
		for (i = 0; i < MAX_TESTS*4; i++)
			golden[i] = {8'hff, 8'(i)};
		$readmemh(GOLDEN_FILE, golden);
		total = 0;
		while (num_tests < MAX_TESTS && golden[num_tests*4][15:8] != 8'hff)
		begin
			total += CYCLES_PER_SAMPLE * int'(golden[num_tests*4+2]);
			num_tests++;
		end
		cycle_limit = total + TIMEOUT_MARGIN * (num_tests + 1);
	endtask

	task automatic check_reset_state();
		int err_before;
		err_before = errors;
		wait (arst_n === 1'b1);
		repeat (SETTLE_CYCLES + 1)
		begin
			@(negedge clock);
			if (out_strobe !== 1'b0)
				report_mismatch("out_strobe", 0, out_strobe);
			if (out_data !== '0)
				report_mismatch("out_data", 0, out_data);
		end
		record_result("reset state", err_before);
	endtask

	task automatic run_test(input int idx);
		rate_log2_t  rate;
		in_sample_t  value;
		out_sample_t expected;
		int          count;
		int          err_before;
		int          start_outs;
		int          exp_outs;
		int          gap;
		int          i;
		rate = rate_log2_t'(golden[idx*4]);
		value = golden[idx*4+1];
		count = int'(golden[idx*4+2]);
		expected = golden[idx*4+3];
		err_before = errors;
		// new rate first, then let the flush pass before any sample
		@(negedge clock);
		rate_log2 = rate;
		cur_rate = rate;
		cur_expected = expected;
		repeat (SETTLE_CYCLES) @(negedge clock);
		start_outs = out_total;
		for (i = 0; i < count; i++)
		begin
			rand_state = next_random(rand_state);
			gap = int'(rand_state[17:16]);
			in_strobe = 1'b0;
			repeat (gap) @(negedge clock);
			in_strobe = 1'b1;
			in_data = value;
			@(negedge clock);
		end
		in_strobe = 1'b0;
		in_data = '0;
		repeat (DRAIN_CYCLES) @(negedge clock);
		// one output per 2**rate accepted samples
		exp_outs = count >> rate;
		if (out_total - start_outs != exp_outs)
			report_mismatch("out_strobe count", exp_outs, out_total - start_outs);
		if (exp_outs > 0 && out_data !== expected)
			report_mismatch("out_data", expected, out_data);
		record_result($sformatf("test %0d rate_log2 %0d value %0d count %0d",
			idx, rate, value, count), err_before);
	endtask

	// counts outputs, checks every rate-1 sample and the zero held before the first output
	always @(negedge clock)
	begin
		if (arst_n && out_strobe)
		begin
			out_total++;
			if (cur_rate == '0 && out_data !== cur_expected)
				report_mismatch("out_data", cur_expected, out_data);
		end
		else if (out_total == 0 && out_data !== '0)
			report_mismatch("out_data", 0, out_data);
	end

	always @(posedge clock)
	begin
		cycles++;
		if (cycle_limit > 0 && cycles > cycle_limit)
		begin
			$display("timeout: run did not finish within %0d cycles", cycle_limit);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	initial
	begin
		int n;
		rate_log2 = '0;
		in_strobe = 1'b0;
		in_data = '0;
		cur_rate = '0;
		cur_expected = '0;
		rand_state = SEED;
		load_golden();
		if (num_tests == 0)
		begin
			$display("golden file %s is missing or holds no tests", GOLDEN_FILE);
			errors++;
		end
		else
		begin
			check_reset_state();
			for (n = 0; n < num_tests; n++)
				run_test(n);
		end
		$display("tests passed %0d, tests failed %0d, errors %0d",
			tests_passed, tests_failed, errors);
		if (errors == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* dv/clock_gen.sv */
// free-running 20 ns clock; reset is released on the falling edge after three rising edges
`timescale 1ns/100ps
`default_nettype none

module clock_gen
(
	output logic clock,
	output logic arst_n
);

	localparam int HALF_PERIOD = 10;
	localparam int RESET_CYCLES = 3;

	initial
	begin
		clock = 1'b0;
		forever
			#(HALF_PERIOD) clock = ~clock;
	end

	// reset low for the first three cycles
	initial
	begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		@(negedge clock);
		arst_n = 1'b1;
	end

endmodule

`default_nettype wire

/* rtl/cic_combs.sv */
// output truncates the top 16 accumulator bits without rounding; no back-pressure
`timescale 1ns/100ps
`default_nettype none

module cic_combs
	import cic_pkg::*;
(
	input  logic        clock,
	input  logic        arst_n,
	input  logic        acc_strobe,
	input  acc_t        acc_data,
	input  acc_t        shifted_data,
	input  logic        bypass,
	input  logic        flush,
	output logic        out_strobe,
	output out_sample_t out_data
);

	acc_t comb_prev [CIC_STAGES];
	acc_t comb_diff [CIC_STAGES];
	acc_t comb_in [CIC_STAGES];
	acc_t stage_q;
	logic stage_stb;

	// differential delay of one, each stage subtracts its previous input
	assign comb_in[0] = acc_data;

	for (genvar k = 0; k < CIC_STAGES; k++)
	begin : g_comb
		assign comb_diff[k] = comb_in[k] - comb_prev[k];
		if (k < CIC_STAGES - 1)
		begin : g_next
			assign comb_in[k+1] = comb_diff[k];
		end
	end

	// whole comb chain settles in one low-rate clock
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int k = 0; k < CIC_STAGES; k++)
				comb_prev[k] <= '0;
			stage_q <= '0;
			stage_stb <= 1'b0;
		end
		else if (flush)
		begin
			for (int k = 0; k < CIC_STAGES; k++)
				comb_prev[k] <= '0;
			stage_q <= '0;
			stage_stb <= 1'b0;
		end
		else
		begin
			stage_stb <= acc_strobe;
			if (acc_strobe)
			begin
				for (int k = 0; k < CIC_STAGES; k++)
					comb_prev[k] <= comb_in[k];
				// rate 1 takes the shifted input, already scaled to the top bits
				stage_q <= bypass ? shifted_data : comb_diff[CIC_STAGES-1];
			end
		end
	end

	// out_data holds between strobes
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			out_strobe <= 1'b0;
			out_data <= '0;
		end
		else
		begin
			out_strobe <= stage_stb && !flush;
			if (stage_stb && !flush)
				out_data <= stage_q[CIC_ACC_WIDTH-1 -: CIC_OUT_WIDTH];
		end
	end

	// the integrator counter spaces decimated strobes at rate 2 and above
	no_back_to_back: assert property (
		@(posedge clock) disable iff (!arst_n || flush)
		acc_strobe && !bypass |=> !acc_strobe
	)
	else
		$error("back-to-back decimated strobes with filter active");

endmodule

`default_nettype wire

/* rtl/cic_decimator.sv */
// fixed six-cycle latency from the R-th accepted input; rate changes flush all filter state
`timescale 1ns/100ps
`default_nettype none

module cic_decimator
	import cic_pkg::*;
(
	input  logic        clock,
	input  logic        arst_n,
	input  rate_log2_t  rate_log2,
	input  logic        in_strobe,
	input  in_sample_t  in_data,
	output logic        out_strobe,
	output out_sample_t out_data
);

	count_t count_last;
	shift_t pre_shift;
	logic   bypass;
	logic   flush;
	logic   acc_strobe;
	acc_t   acc_data;
	acc_t   shifted_data;

	cic_rate_decode i_cic_rate_decode (
		.clock      (clock),
		.arst_n     (arst_n),
		.rate_log2  (rate_log2),
		.count_last (count_last),
		.pre_shift  (pre_shift),
		.bypass     (bypass),
		.flush      (flush)
	);

	// full-rate section
	cic_integrators i_cic_integrators (
		.clock        (clock),
		.arst_n       (arst_n),
		.in_strobe    (in_strobe),
		.in_data      (in_data),
		.count_last   (count_last),
		.pre_shift    (pre_shift),
		.flush        (flush),
		.acc_strobe   (acc_strobe),
		.acc_data     (acc_data),
		.shifted_data (shifted_data)
	);

	// decimated section
	cic_combs i_cic_combs (
		.clock        (clock),
		.arst_n       (arst_n),
		.acc_strobe   (acc_strobe),
		.acc_data     (acc_data),
		.shifted_data (shifted_data),
		.bypass       (bypass),
		.flush        (flush),
		.out_strobe   (out_strobe),
		.out_data     (out_data)
	);

endmodule

`default_nettype wire

/* rtl/cic_integrators.sv */
// integrators wrap at 40 bits; a strobe that coincides with flush is dropped
`timescale 1ns/100ps
`default_nettype none

module cic_integrators
	import cic_pkg::*;
(
	input  logic       clock,
	input  logic       arst_n,
	input  logic       in_strobe,
	input  in_sample_t in_data,
	input  count_t     count_last,
	input  shift_t     pre_shift,
	input  logic       flush,
	output logic       acc_strobe,
	output acc_t       acc_data,
	output acc_t       shifted_data
);

	acc_t                in_ext;
	acc_t                shifted_q;
	acc_t                shift_pipe [CIC_STAGES];
	acc_t                integ [CIC_STAGES];
	acc_t                integ_in [CIC_STAGES];
	logic [CIC_STAGES:0] stb;
	count_t              sample_no;

	// sign extension to accumulator width
	assign in_ext = in_data;

	// pre-shift register and the strobe that follows each sample down the chain
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			shifted_q <= '0;
			stb <= '0;
		end
		else if (flush)
		begin
			shifted_q <= '0;
			stb <= '0;
		end
		else
		begin
			stb <= {stb[CIC_STAGES-1:0], in_strobe};
			if (in_strobe)
				shifted_q <= in_ext << pre_shift;
		end
	end

	// each stage sums the registered output of the one before
	assign integ_in[0] = shifted_q;

	for (genvar k = 1; k < CIC_STAGES; k++)
	begin : g_chain
		assign integ_in[k] = integ[k-1];
	end

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int k = 0; k < CIC_STAGES; k++)
				integ[k] <= '0;
		end
		else if (flush)
		begin
			for (int k = 0; k < CIC_STAGES; k++)
				integ[k] <= '0;
		end
		else
		begin
			for (int k = 0; k < CIC_STAGES; k++)
				if (stb[k])
					integ[k] <= integ[k] + integ_in[k];
		end
	end

	// delay the shifted input so it lines up with the last integrator, used for rate 1
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int k = 0; k < CIC_STAGES; k++)
				shift_pipe[k] <= '0;
		end
		else
		begin
			shift_pipe[0] <= shifted_q;
			for (int k = 1; k < CIC_STAGES; k++)
				shift_pipe[k] <= shift_pipe[k-1];
		end
	end

	// marks every R-th sample leaving the last integrator
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
			sample_no <= '0;
		else if (flush)
			sample_no <= '0;
		else if (stb[CIC_STAGES])
			sample_no <= (sample_no == count_last) ? '0 : sample_no + 1'b1;
	end

	assign acc_strobe = stb[CIC_STAGES] && (sample_no == count_last);
	assign acc_data = integ[CIC_STAGES-1];
	assign shifted_data = shift_pipe[CIC_STAGES-1];

	// count_last moves one cycle ahead of the flush that resets the counter
	count_in_range: assert property (
		@(posedge clock) disable iff (!arst_n)
		!flush |-> sample_no <= count_last
	)
	else
		$error("sample counter %0d above limit %0d", sample_no, count_last);

endmodule

`default_nettype wire

/* rtl/cic_pkg.sv */
// shared widths and types for the CIC decimator; rates are powers of two up to 256 only
`default_nettype none

package cic_pkg;

	// filter structure, differential delay fixed at one
	localparam int CIC_STAGES = 3;

	// sample widths at the filter boundary
	localparam int CIC_IN_WIDTH = 16;
	localparam int CIC_OUT_WIDTH = 16;

	// largest supported rate is 2**8
	localparam int CIC_RATE_LOG2_MAX = 8;

	// worst-case growth sizes every accumulator, no pruning
	localparam int CIC_GROWTH = CIC_STAGES * CIC_RATE_LOG2_MAX;
	localparam int CIC_ACC_WIDTH = CIC_IN_WIDTH + CIC_GROWTH;

	// counter runs 0 to rate-1
	localparam int CIC_COUNT_WIDTH = CIC_RATE_LOG2_MAX;

	// code and shift field widths
	localparam int CIC_RATE_WIDTH = 4;
	localparam int CIC_SHIFT_WIDTH = 5;

	typedef logic signed [CIC_IN_WIDTH-1:0] in_sample_t;

	typedef logic signed [CIC_OUT_WIDTH-1:0] out_sample_t;

	// integrator and comb word, wraps on overflow by design
	typedef logic signed [CIC_ACC_WIDTH-1:0] acc_t;

	typedef logic [CIC_RATE_WIDTH-1:0] rate_log2_t;

	typedef logic [CIC_COUNT_WIDTH-1:0] count_t;

	// left shift applied to the input, 0 to CIC_GROWTH
	typedef logic [CIC_SHIFT_WIDTH-1:0] shift_t;

endpackage

`default_nettype wire

/* rtl/cic_rate_decode.sv */
// rate_log2 must stay within 0..8; any change costs one flush cycle and drops in-flight samples
`timescale 1ns/100ps
`default_nettype none

module cic_rate_decode
	import cic_pkg::*;
(
	input  logic       clock,
	input  logic       arst_n,
	input  rate_log2_t rate_log2,
	output count_t     count_last,
	output shift_t     pre_shift,
	output logic       bypass,
	output logic       flush
);

	rate_log2_t                 rate_q;
	logic [CIC_COUNT_WIDTH:0]   rate_value;

	// registered rate code plus change detect
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			rate_q <= '0;
			flush <= 1'b0;
		end
		else
		begin
			rate_q <= rate_log2;
			// pulse lasts one cycle since rate_q catches up on the same edge
			flush <= (rate_log2 != rate_q);
		end
	end

	// decimation factor, one bit wider than the counter to hold 256
	assign rate_value = {{CIC_COUNT_WIDTH{1'b0}}, 1'b1} << rate_q;

	// counter wraps after rate-1
	assign count_last = count_t'(rate_value - 1'b1);

	// gain is rate**3, i.e. 3*rate_log2 bits of growth
	// shift the input so that growth always ends at the accumulator top
	assign pre_shift = shift_t'(CIC_GROWTH - CIC_STAGES * int'(rate_q));

	// rate 1 skips the filter
	assign bypass = (rate_q == '0);

	// codes beyond the maximum would overflow the accumulators
	rate_in_range: assert property (
		@(posedge clock) disable iff (!arst_n)
		rate_log2 <= rate_log2_t'(CIC_RATE_LOG2_MAX)
	)
	else
		$error("rate_log2 %0d above maximum %0d", rate_log2, CIC_RATE_LOG2_MAX);

endmodule

`default_nettype wire

/* sources.f */
rtl/cic_pkg.sv
rtl/cic_rate_decode.sv
rtl/cic_integrators.sv
rtl/cic_combs.sv
rtl/cic_decimator.sv
dv/clock_gen.sv
dv/cic_tb.sv
